// ==== cache_response_input.txt ====
# Columns in hex: cmd tag addr data mask (cmd 0 read, 1 write, 2 program, 3 flush)
# Mask bit 0 is requestor 0, bit 1 is requestor 1
0 00 00001000 a5a50000 2
1 01 00001004 0badf00d 2
2 02 00002000 12345678 3
3 03 00003000 00000000 1
0 04 00001008 ffffffff 2
1 05 0000100c 5a5a5a5a 2
2 06 00002004 87654321 3
3 07 00003004 deadbeef 1
0 08 80000000 00000001 2
1 09 80000004 00000002 2
0 0a 80000008 00000004 2
2 0b 00002008 cafef00d 3
3 0c 00003008 11111111 1
1 0d 8000000c 00000008 2
0 0e 80000010 00000010 2
3 0f 0000300c 22222222 1
2 10 0000200c 33333333 3
1 11 7ffffffc 44444444 2
0 12 00000000 55555555 2
3 13 00003010 66666666 1
2 14 00002010 77777777 3
1 15 fffffffc 88888888 2
0 16 12340000 99999999 2
1 17 12340004 aaaaaaaa 2
3 18 00003014 bbbbbbbb 1
2 19 00002014 cccccccc 3
0 1a 12340008 dddddddd 2
1 1b 1234000c eeeeeeee 2
0 1c 40000000 01234567 2
3 1d 00003018 89abcdef 1
2 1e 00002018 fedcba98 3
1 1f 40000004 76543210 2
0 20 40000008 13579bdf 2
1 21 4000000c 2468ace0 2
2 22 0000201c 0f0f0f0f 3
3 23 0000301c f0f0f0f0 1
0 24 40000010 00ff00ff 2
1 25 40000014 ff00ff00 2
3 26 00003020 80000001 1
2 27 00002020 7ffffffe 3
0 28 55550000 3c3c3c3c 2
1 29 55550004 c3c3c3c3 2
0 2a aaaa0000 96969696 2
2 2b 00002024 69696969 3
3 2c 00003024 a0a0a0a0 1
1 2d aaaa0004 0a0a0a0a 2
0 2e 0000fff0 10203040 2
2 2f 00002028 50607080 3
3 30 00003028 90a0b0c0 1
1 31 0000fff4 d0e0f000 2

// ==== compile.f ====
cache_response_pkg.sv
response_sync_fifo.sv
cache_response_router.sv
cache_response_top.sv
tb_cache_response.sv

// ==== tb_cache_response.sv ====
// Testbench for the cache response path
// Reads responses from the stimulus file, routes them through the DUT
// and checks both requestor outputs, order under back-pressure and flags
module tb_cache_response
  import cache_response_pkg::*;
();

  localparam int MAX_ENTRIES    = 64;
  localparam int FLAG_SETUP     = 0;
  localparam int FLAG_EMPTY     = 1;
  localparam int FLAG_PROG_FULL = 2;
  localparam int FLAG_FULL      = 3;

  logic                ap_clk;
  logic                areset_control;
  logic                resp_valid;
  cmd_t                resp_cmd;
  logic [TAG_W-1:0]    resp_tag;
  logic [ADDR_W-1:0]   resp_addr;
  logic [DATA_W-1:0]   resp_data;
  logic                fifo_rd_en;
  logic                fifo_full;
  logic                fifo_empty;
  logic                fifo_prog_full;
  logic                fifo_valid;
  logic                fifo_setup;
  logic                pkt0_valid;
  logic [PACKET_W-1:0] pkt0_payload;
  logic                pkt1_valid;
  logic [PACKET_W-1:0] pkt1_payload;

  // Stimulus table loaded from the data file
  logic [1:0]          file_cmd  [MAX_ENTRIES];
  logic [TAG_W-1:0]    file_tag  [MAX_ENTRIES];
  logic [ADDR_W-1:0]   file_addr [MAX_ENTRIES];
  logic [DATA_W-1:0]   file_data [MAX_ENTRIES];
  logic [1:0]          file_mask [MAX_ENTRIES];
  int                  n_entries;

  // Expected packets per requestor, in input order
  logic [PACKET_W-1:0] exp_q0 [$];
  logic [PACKET_W-1:0] exp_q1 [$];

  int                  mismatch_count;
  int                  timeout_count;
  int                  other_count;

  cache_response_top #(
    .FIFO_DEPTH (32),
    .PROG_THRESH(16)
  ) i_cache_response_top (
    .ap_clk        (ap_clk),
    .areset_control(areset_control),
    .resp_valid    (resp_valid),
    .resp_cmd      (resp_cmd),
    .resp_tag      (resp_tag),
    .resp_addr     (resp_addr),
    .resp_data     (resp_data),
    .fifo_rd_en    (fifo_rd_en),
    .fifo_full     (fifo_full),
    .fifo_empty    (fifo_empty),
    .fifo_prog_full(fifo_prog_full),
    .fifo_valid    (fifo_valid),
    .fifo_setup    (fifo_setup),
    .pkt0_valid    (pkt0_valid),
    .pkt0_payload  (pkt0_payload),
    .pkt1_valid    (pkt1_valid),
    .pkt1_payload  (pkt1_payload)
  );

  initial begin
    ap_clk = 1'b0;
    forever #5 ap_clk = ~ap_clk;
  end

  // ----------------------------------------------------------------------
  // Helpers
  // ----------------------------------------------------------------------
  task automatic check_value(input string name, input logic [PACKET_W-1:0] actual,
                             input logic [PACKET_W-1:0] expected);
    if (actual !== expected) begin
      mismatch_count++;
      $display("ERROR at %0t: %s is %h, expected %h", $time, name, actual, expected);
    end
  endtask

  // Routing rule: program to both, flush to 0, the rest to 1
  function automatic logic [1:0] rule_mask(input logic [1:0] cmd);
    case (cmd_t'(cmd))
      cmd_mem_program: rule_mask = 2'b11;
      cmd_mem_flush:   rule_mask = 2'b01;
      default:         rule_mask = 2'b10;
    endcase
  endfunction

  function automatic logic read_flag(input int sel);
    case (sel)
      FLAG_SETUP:     read_flag = fifo_setup;
      FLAG_EMPTY:     read_flag = fifo_empty;
      FLAG_PROG_FULL: read_flag = fifo_prog_full;
      FLAG_FULL:      read_flag = fifo_full;
      default:        read_flag = 1'bx;
    endcase
  endfunction

  task automatic wait_flag(input int sel, input logic level, input string name,
                           input int limit);
    int cycles;
    cycles = 0;
    while (read_flag(sel) !== level && cycles < limit) begin
      @(negedge ap_clk);
      cycles++;
    end
    if (read_flag(sel) !== level) begin
      timeout_count++;
      $display("Timeout at %0t: %s did not reach %b within %0d cycles",
               $time, name, level, limit);
    end
  endtask

  // Both expectation queues empty, or give up
  task automatic wait_drained(input int limit);
    int cycles;
    cycles = 0;
    while ((exp_q0.size() != 0 || exp_q1.size() != 0) && cycles < limit) begin
      @(negedge ap_clk);
      cycles++;
    end
    if (exp_q0.size() != 0 || exp_q1.size() != 0) begin
      timeout_count++;
      $display("Timeout at %0t: %0d packets for requestor 0 and %0d for requestor 1 never came",
               $time, exp_q0.size(), exp_q1.size());
    end
  endtask

  task automatic load_stimulus();
    integer fd;
    string  line;
    int     cnt;
    logic [31:0] c, t, a, d, m;
    n_entries = 0;
    fd = $fopen("cache_response_input.txt", "r");
    if (fd == 0) begin
      other_count++;
      $display("Could not open the stimulus file cache_response_input.txt");
    end else begin
      while (!$feof(fd) && n_entries < MAX_ENTRIES) begin
        line = "";
        cnt  = $fgets(line, fd);
        // Skip comments and blank lines
        if (line.len() > 1 && line.getc(0) != "#") begin
          cnt = $sscanf(line, "%h %h %h %h %h", c, t, a, d, m);
          if (cnt == 5) begin
            file_cmd[n_entries]  = c[1:0];
            file_tag[n_entries]  = t[TAG_W-1:0];
            file_addr[n_entries] = a;
            file_data[n_entries] = d;
            file_mask[n_entries] = m[1:0];
            // Data file mask against the routing rule
            check_value($sformatf("dest_mask[%0d]", n_entries), m[1:0], rule_mask(c[1:0]));
            n_entries++;
          end
        end
      end
      $fclose(fd);
    end
  endtask

  // Drive one response and queue its packet for each flagged requestor
  task automatic send_entry(input int idx);
    logic [PACKET_W-1:0] pkt;
    resp_valid = 1'b1;
    resp_cmd   = cmd_t'(file_cmd[idx]);
    resp_tag   = file_tag[idx];
    resp_addr  = file_addr[idx];
    resp_data  = file_data[idx];
    // Memory packet layout: tag, cmd, addr, data
    pkt = {file_tag[idx], file_cmd[idx], file_addr[idx], file_data[idx]};
    if (file_mask[idx][0]) exp_q0.push_back(pkt);
    if (file_mask[idx][1]) exp_q1.push_back(pkt);
  endtask

  // Back-to-back responses, one per cycle
  task automatic send_block(input int first, input int count);
    for (int i = first; i < first + count; i++) begin
      send_entry(i % n_entries);
      @(negedge ap_clk);
    end
    resp_valid = 1'b0;
  endtask

  task automatic check_idle_flags(input logic setup_exp);
    check_value("pkt0_valid", pkt0_valid, 1'b0);
    check_value("pkt1_valid", pkt1_valid, 1'b0);
    check_value("fifo_valid", fifo_valid, 1'b0);
    check_value("fifo_empty", fifo_empty, 1'b1);
    check_value("fifo_full", fifo_full, 1'b0);
    check_value("fifo_prog_full", fifo_prog_full, 1'b0);
    check_value("fifo_setup", fifo_setup, setup_exp);
  endtask

  // ----------------------------------------------------------------------
  // Output monitor
  // ----------------------------------------------------------------------
  always @(posedge ap_clk) begin
    // Every popped entry reaches at least one requestor in the same cycle
    if (!areset_control) begin
      check_value("fifo_valid", fifo_valid, pkt0_valid | pkt1_valid);
    end
    if (!areset_control && pkt0_valid) begin
      if (exp_q0.size() == 0) begin
        other_count++;
        $display("Unexpected packet on requestor 0 at time %0t", $time);
      end else begin
        check_value("pkt0_payload", pkt0_payload, exp_q0.pop_front());
      end
    end
    if (!areset_control && pkt1_valid) begin
      if (exp_q1.size() == 0) begin
        other_count++;
        $display("Unexpected packet on requestor 1 at time %0t", $time);
      end else begin
        check_value("pkt1_payload", pkt1_payload, exp_q1.pop_front());
      end
    end
  end

  // ----------------------------------------------------------------------
  // Main sequence
  // ----------------------------------------------------------------------
  initial begin
    int sent;
    int cycles;
    mismatch_count = 0;
    timeout_count  = 0;
    other_count    = 0;
    void'($urandom(56));
    areset_control = 1'b1;
    resp_valid     = 1'b0;
    resp_cmd       = cmd_mem_read;
    resp_tag       = '0;
    resp_addr      = '0;
    resp_data      = '0;
    fifo_rd_en     = 1'b0;
    load_stimulus();

    // Reset state, then setup drops a few cycles after release
    repeat (16) @(negedge ap_clk);
    check_idle_flags(1'b1);
    areset_control = 1'b0;
    @(negedge ap_clk);
    check_idle_flags(1'b1);
    wait_flag(FLAG_SETUP, 1'b0, "fifo_setup", 20);
    check_idle_flags(1'b0);

    if (n_entries < 32) begin
      other_count++;
      $display("Stimulus file holds %0d responses, at least 32 are needed", n_entries);
    end else begin
      // Routing with the read enable held high
      fifo_rd_en = 1'b1;
      send_block(0, n_entries);
      wait_drained(200);

      // Random read back-pressure, sends held off near prog_full
      sent   = 0;
      cycles = 0;
      while (sent < n_entries && cycles < 40 * n_entries) begin
        fifo_rd_en = (($urandom & 1) != 0);
        if (!fifo_prog_full && (($urandom & 1) != 0)) begin
          send_entry(sent);
          sent++;
        end else begin
          resp_valid = 1'b0;
        end
        @(negedge ap_clk);
        cycles++;
      end
      resp_valid = 1'b0;
      if (sent < n_entries) begin
        timeout_count++;
        $display("Timeout at %0t: only %0d of %0d responses were sent", $time, sent, n_entries);
      end
      fifo_rd_en = 1'b1;
      wait_drained(300);

      // Fill with reads stopped
      fifo_rd_en = 1'b0;
      @(negedge ap_clk);
      send_block(0, 16);
      wait_flag(FLAG_PROG_FULL, 1'b1, "fifo_prog_full", 20);
      send_block(16, 16);
      wait_flag(FLAG_FULL, 1'b1, "fifo_full", 20);
      check_value("fifo_valid", fifo_valid, 1'b0);
      check_value("fifo_empty", fifo_empty, 1'b0);

      // Drain everything stored
      fifo_rd_en = 1'b1;
      wait_drained(200);
      wait_flag(FLAG_EMPTY, 1'b1, "fifo_empty", 20);
      wait_flag(FLAG_PROG_FULL, 1'b0, "fifo_prog_full", 20);
    end

    $display("Error counts: %0d mismatches, %0d timeouts, %0d other failures",
             mismatch_count, timeout_count, other_count);
    if (mismatch_count + timeout_count + other_count == 0) begin
      $display("TEST PASSED");
    end else begin
      $display("TEST FAILED");
    end
    $finish;
  end

endmodule : tb_cache_response

// ==== cache_response_top.sv ====
// Cache response path top level
// Sets the FIFO depth and threshold and connects the router outward
module cache_response_top
  import cache_response_pkg::*;
#(
  parameter int FIFO_DEPTH  = 32,
  parameter int PROG_THRESH = 16
) (
  input  logic                ap_clk,
  input  logic                areset_control,
  input  logic                resp_valid,
  input  cmd_t                resp_cmd,
  input  logic [TAG_W-1:0]    resp_tag,
  input  logic [ADDR_W-1:0]   resp_addr,
  input  logic [DATA_W-1:0]   resp_data,
  input  logic                fifo_rd_en,
  output logic                fifo_full,
  output logic                fifo_empty,
  output logic                fifo_prog_full,
  output logic                fifo_valid,
  output logic                fifo_setup,
  output logic                pkt0_valid,
  output logic [PACKET_W-1:0] pkt0_payload,
  output logic                pkt1_valid,
  output logic [PACKET_W-1:0] pkt1_payload
);

  // ----------------------------------------------------------------------
  // Response router
  // ----------------------------------------------------------------------
  cache_response_router #(
    .FIFO_DEPTH (FIFO_DEPTH),
    .PROG_THRESH(PROG_THRESH)
  ) i_cache_response_router (
    .ap_clk        (ap_clk),
    .areset_control(areset_control),
    .resp_valid    (resp_valid),
    .resp_cmd      (resp_cmd),
    .resp_tag      (resp_tag),
    .resp_addr     (resp_addr),
    .resp_data     (resp_data),
    .fifo_rd_en    (fifo_rd_en),
    .fifo_full     (fifo_full),
    .fifo_empty    (fifo_empty),
    .fifo_prog_full(fifo_prog_full),
    .fifo_valid    (fifo_valid),
    .fifo_setup    (fifo_setup),
    .pkt0_valid    (pkt0_valid),
    .pkt0_payload  (pkt0_payload),
    .pkt1_valid    (pkt1_valid),
    .pkt1_payload  (pkt1_payload)
  );

endmodule : cache_response_top

// ==== cache_response_router.sv ====
// Cache response router
// Registers incoming responses, buffers them in a FIFO and steers each
// popped packet to memory requestor 0, 1 or both by its command
module cache_response_router
  import cache_response_pkg::*;
#(
  parameter int FIFO_DEPTH  = 32,
  parameter int PROG_THRESH = 16
) (
  input  logic                ap_clk,
  input  logic                areset_control,
  input  logic                resp_valid,
  input  cmd_t                resp_cmd,
  input  logic [TAG_W-1:0]    resp_tag,
  input  logic [ADDR_W-1:0]   resp_addr,
  input  logic [DATA_W-1:0]   resp_data,
  input  logic                fifo_rd_en,
  output logic                fifo_full,
  output logic                fifo_empty,
  output logic                fifo_prog_full,
  output logic                fifo_valid,
  output logic                fifo_setup,
  output logic                pkt0_valid,
  output logic [PACKET_W-1:0] pkt0_payload,
  output logic                pkt1_valid,
  output logic [PACKET_W-1:0] pkt1_payload
);

  // ----------------------------------------------------------------------
  // Input registers
  // ----------------------------------------------------------------------
  logic                       resp_valid_q;
  cmd_t                       resp_cmd_q;
  logic [TAG_W-1:0]           resp_tag_q;
  logic [ADDR_W-1:0]          resp_addr_q;
  logic [DATA_W-1:0]          resp_data_q;
  logic                       rd_en_q;

  // FIFO side
  logic [CACHE_PAYLOAD_W-1:0] fifo_din;
  logic [CACHE_PAYLOAD_W-1:0] fifo_dout;
  logic                       fifo_pop;
  logic                       full_int;
  logic                       empty_int;
  logic                       valid_int;
  logic                       prog_full_int;
  logic                       wr_rst_busy;
  logic                       rd_rst_busy;

  // Demux stage
  logic [PACKET_W-1:0]        mem_pkt;
  cmd_t                       pkt_cmd;
  logic                       route0;
  logic                       route1;

  // Strobe and read enable are control, reset them
  always_ff @(posedge ap_clk) begin
    if (areset_control) begin
      resp_valid_q <= 1'b0;
      rd_en_q      <= 1'b0;
    end else begin
      resp_valid_q <= resp_valid;
      rd_en_q      <= fifo_rd_en;
    end
  end

  always_ff @(posedge ap_clk) begin
    resp_cmd_q  <= resp_cmd;
    resp_tag_q  <= resp_tag;
    resp_addr_q <= resp_addr;
    resp_data_q <= resp_data;
  end

  // ----------------------------------------------------------------------
  // Response FIFO
  // ----------------------------------------------------------------------
  // Packed as {cmd, tag, addr, data}
  assign fifo_din = {resp_cmd_q, resp_tag_q, resp_addr_q, resp_data_q};
  // Pop only what is there
  assign fifo_pop = rd_en_q & ~empty_int;

  response_sync_fifo #(
    .DEPTH      (FIFO_DEPTH),
    .WIDTH      (CACHE_PAYLOAD_W),
    .PROG_THRESH(PROG_THRESH)
  ) i_response_sync_fifo (
    .ap_clk        (ap_clk),
    .areset_control(areset_control),
    .din           (fifo_din),
    .wr_en         (resp_valid_q),
    .rd_en         (fifo_pop),
    .dout          (fifo_dout),
    .full          (full_int),
    .empty         (empty_int),
    .valid         (valid_int),
    .prog_full     (prog_full_int),
    .wr_rst_busy   (wr_rst_busy),
    .rd_rst_busy   (rd_rst_busy)
  );

  // ----------------------------------------------------------------------
  // Command demux
  // ----------------------------------------------------------------------
  assign mem_pkt = to_memory_packet(fifo_dout);
  assign pkt_cmd = cmd_t'(mem_pkt[PK_CMD_LSB +: CMD_W]);

  always_comb begin
    route0 = 1'b0;
    route1 = 1'b0;
    if (valid_int) begin
      case (pkt_cmd)
        // Program goes to both requestors
        cmd_mem_program: begin
          route0 = 1'b1;
          route1 = 1'b1;
        end
        cmd_mem_flush: route0 = 1'b1;
        default:       route1 = 1'b1;
      endcase
    end
  end

  // Output strobes and FIFO flags
  always_ff @(posedge ap_clk) begin
    if (areset_control) begin
      pkt0_valid     <= 1'b0;
      pkt1_valid     <= 1'b0;
      fifo_full      <= 1'b0;
      fifo_empty     <= 1'b1;
      fifo_prog_full <= 1'b0;
      fifo_valid     <= 1'b0;
      fifo_setup     <= 1'b1;
    end else begin
      pkt0_valid     <= route0;
      pkt1_valid     <= route1;
      fifo_full      <= full_int;
      fifo_empty     <= empty_int;
      fifo_prog_full <= prog_full_int;
      fifo_valid     <= valid_int;
      // Setup while either side of the FIFO is busy
      fifo_setup     <= wr_rst_busy | rd_rst_busy;
    end
  end

  // Payloads held until the next packet for that requestor
  always_ff @(posedge ap_clk) begin
    if (route0) begin
      pkt0_payload <= mem_pkt;
    end
    if (route1) begin
      pkt1_payload <= mem_pkt;
    end
  end

  // ----------------------------------------------------------------------
  // Assertions
  // ----------------------------------------------------------------------
  // Every output packet comes from a FIFO pop two cycles earlier
  a_pkt_after_fifo_valid : assert property (@(posedge ap_clk) disable iff (areset_control)
    (pkt0_valid || pkt1_valid) |-> $past(fifo_pop, 2));

  // Requestor 1 never carries a flush packet
  a_flush_not_on_pkt1 : assert property (@(posedge ap_clk) disable iff (areset_control)
    pkt1_valid |-> (pkt1_payload[PK_CMD_LSB +: CMD_W] != cmd_mem_flush));

endmodule : cache_response_router

// ==== response_sync_fifo.sv ====
// Synchronous FIFO for cache responses
// Circular buffer with occupancy count, prog_full threshold,
// registered read data with a valid strobe, and reset-busy flags
module response_sync_fifo
  import cache_response_pkg::*;
#(
  parameter int DEPTH       = 32,
  parameter int WIDTH       = 74,
  parameter int PROG_THRESH = 16
) (
  input  logic             ap_clk,
  input  logic             areset_control,
  input  logic [WIDTH-1:0] din,
  input  logic             wr_en,
  input  logic             rd_en,
  output logic [WIDTH-1:0] dout,
  output logic             full,
  output logic             empty,
  output logic             valid,
  output logic             prog_full,
  output logic             wr_rst_busy,
  output logic             rd_rst_busy
);

  localparam int AW = (DEPTH > 1) ? $clog2(DEPTH) : 1;
  localparam int CW = $clog2(DEPTH + 1);
  localparam int BW = $clog2(RST_BUSY_CYCLES + 1);

  // ----------------------------------------------------------------------
  // Storage and pointers
  // ----------------------------------------------------------------------
  logic [WIDTH-1:0] mem [DEPTH];
  logic [AW-1:0]    wr_ptr;
  logic [AW-1:0]    rd_ptr;
  logic [CW-1:0]    count;
  logic [BW-1:0]    busy_cnt;
  logic             busy;
  logic             wr_ok;
  logic             rd_ok;

  // Busy while the post-reset counter runs down
  assign busy        = (busy_cnt != '0);
  assign wr_rst_busy = busy;
  assign rd_rst_busy = busy;

  // Flags from the occupancy count
  assign empty     = (count == '0);
  assign full      = (count == CW'(DEPTH));
  assign prog_full = (count >= CW'(PROG_THRESH));

  // Accepted operations, both blocked while busy
  assign wr_ok = wr_en & ~full & ~busy;
  assign rd_ok = rd_en & ~empty & ~busy;

  always_ff @(posedge ap_clk) begin
    if (areset_control) begin
      busy_cnt <= BW'(RST_BUSY_CYCLES);
    end else if (busy) begin
      busy_cnt <= busy_cnt - 1'b1;
    end
  end

  // ----------------------------------------------------------------------
  // Pointer and count update
  // ----------------------------------------------------------------------
  always_ff @(posedge ap_clk) begin
    if (areset_control) begin
      wr_ptr <= '0;
      rd_ptr <= '0;
      count  <= '0;
      valid  <= 1'b0;
    end else begin
      if (wr_ok) begin
        // Wrap explicitly, depth need not be a power of two
        wr_ptr <= (wr_ptr == AW'(DEPTH - 1)) ? '0 : wr_ptr + 1'b1;
      end
      if (rd_ok) begin
        rd_ptr <= (rd_ptr == AW'(DEPTH - 1)) ? '0 : rd_ptr + 1'b1;
      end
      case ({wr_ok, rd_ok})
        2'b10:   count <= count + 1'b1;
        2'b01:   count <= count - 1'b1;
        default: count <= count;
      endcase
      // Read data shows up one cycle after the pop
      valid <= rd_ok;
    end
  end

  // Payload path
  always_ff @(posedge ap_clk) begin
    if (wr_ok) begin
      mem[wr_ptr] <= din;
    end
    if (rd_ok) begin
      dout <= mem[rd_ptr];
    end
  end

  // ----------------------------------------------------------------------
  // Assertions
  // ----------------------------------------------------------------------
  // Write into a full FIFO leaves the write pointer alone
  a_no_write_when_full : assert property (@(posedge ap_clk) disable iff (areset_control)
    (wr_en && full) |=> (wr_ptr == $past(wr_ptr)));

  // Read of an empty FIFO never produces valid data
  a_no_read_when_empty : assert property (@(posedge ap_clk) disable iff (areset_control)
    (rd_en && empty) |=> !valid);

  a_count_bound : assert property (@(posedge ap_clk) disable iff (areset_control)
    count <= CW'(DEPTH));

endmodule : response_sync_fifo

// ==== cache_response_pkg.sv ====
// Cache response path shared definitions
// Field widths, memory command encoding and the conversion from a
// cache response payload to a memory packet payload
package cache_response_pkg;

  // ----------------------------------------------------------------------
  // Field widths
  // ----------------------------------------------------------------------
  localparam int CMD_W  = 2;
  localparam int TAG_W  = 8;
  localparam int ADDR_W = 32;
  localparam int DATA_W = 32;

  // Cache payload {cmd, tag, addr, data}
  localparam int CACHE_PAYLOAD_W = CMD_W + TAG_W + ADDR_W + DATA_W;
  // Memory packet {tag, cmd, addr, data}
  localparam int PACKET_W        = TAG_W + CMD_W + ADDR_W + DATA_W;

  // Bit offsets inside a cache payload
  localparam int CP_ADDR_LSB = DATA_W;
  localparam int CP_TAG_LSB  = CP_ADDR_LSB + ADDR_W;
  localparam int CP_CMD_LSB  = CP_TAG_LSB + TAG_W;

  // Command field offset inside a memory packet
  localparam int PK_CMD_LSB = DATA_W + ADDR_W;

  // Cycles the FIFO stays busy after reset
  localparam int RST_BUSY_CYCLES = 4;

  // ----------------------------------------------------------------------
  // Memory commands
  // ----------------------------------------------------------------------
  typedef enum logic [CMD_W-1:0] {
    cmd_mem_read    = 2'd0,
    cmd_mem_write   = 2'd1,
    cmd_mem_program = 2'd2,
    cmd_mem_flush   = 2'd3
  } cmd_t;

  // Reorder cache payload fields into the memory packet layout
  function automatic logic [PACKET_W-1:0] to_memory_packet(
    input logic [CACHE_PAYLOAD_W-1:0] cache_payload
  );
    logic [CMD_W-1:0]  cmd;
    logic [TAG_W-1:0]  tag;
    logic [ADDR_W-1:0] addr;
    logic [DATA_W-1:0] data;
    cmd  = cache_payload[CP_CMD_LSB +: CMD_W];
    tag  = cache_payload[CP_TAG_LSB +: TAG_W];
    addr = cache_payload[CP_ADDR_LSB +: ADDR_W];
    data = cache_payload[0 +: DATA_W];
    // Tag moves ahead of the command
    return {tag, cmd, addr, data};
  endfunction

endpackage : cache_response_pkg
